/* design/nand_config.svh */
//==========================================================================
// Register map and constants of the NAND flash controller.
// Offsets are matched against HADDR[5:0] only; upper address bits are
// ignored, so the slave window repeats every 64 bytes.
// Timing fields hold n for a phase of n+1 HCLK cycles.
//==========================================================================
`ifndef NAND_CONFIG_SVH
`define NAND_CONFIG_SVH

//==========================================================================
// register offsets
//==========================================================================
`define NAND_CMD_OFS    6'b001000  // command byte in HWDATA[7:0]
`define NAND_ADR_OFS    6'b001010  // four address bytes
`define NAND_STATUS_OFS 6'b001110  // read rb, write starts flash reset
`define NAND_CFG_OFS    6'b010010  // timing register
`define NAND_DATA_OFS   6'b010101  // four data bytes, read or write

//==========================================================================
// flash constants
//==========================================================================
`define NAND_RESET_CMD  8'hFF      // sent on a status write

// bytes per bus word, and number of address cycles
`define NAND_WORD_BYTES 4

`define NAND_TCNT_W     3          // width of one timing field

`endif

/* design/nandPkg.sv */
//==========================================================================
// Types shared by the NAND controller blocks.
// The timing register layout is {hold, strobe, setup}, setup in bits 2:0.
// Sequencer requests are one-cycle strobes qualified by valid.
//==========================================================================
package nandPkg;

  `include "nand_config.svh"

  typedef logic [7:0]             byte_t;     // flash data byte
  typedef logic [31:0]            word_t;     // bus word
  typedef logic [5:0]             regOfs_t;   // register offset
  typedef logic [`NAND_TCNT_W-1:0] timeCnt_t; // n means n+1 cycles

  typedef struct packed {
    timeCnt_t hold;
    timeCnt_t strobe;
    timeCnt_t setup;
  } nandTiming_t;

  typedef struct packed {
    logic  cle;
    logic  ceN;
    logic  weN;
    logic  ale;
    logic  reN;
    logic  dataEn;   // drive dataOut onto the flash bus
    byte_t dataOut;
  } nandPins_t;

  typedef enum logic [1:0] {
    seqCmd,
    seqAddr,
    seqWrite,
    seqRead
  } seqKind_t;

  typedef struct packed {
    logic     valid;
    seqKind_t kind;
    word_t    payload;
  } seqReq_t;

  typedef enum logic [1:0] {
    idle,
    setup,
    strobe,
    hold
  } seqState_t;

endpackage

/* design/ahbRegs.sv */
//==========================================================================
// AHB-Lite register slave of the NAND controller.
// No wait state for timing and status accesses; command, address, data
// and status writes and data reads stall HREADYOUT until the sequencer
// finishes. HRESP is not provided, the slave never errors.
// rb is synchronized in two stages and assumed ready out of reset.
//==========================================================================
`timescale 1ns/10ps
`include "nand_config.svh"

module ahbRegs (
  input  logic                 HCLK,
  input  logic                 HRST_N,
  input  logic                 HSEL,
  input  logic                 HWRITE,
  input  logic                 HREADY,
  input  logic [1:0]           HTRANS,
  input  nandPkg::word_t       HADDR,
  input  nandPkg::word_t       HWDATA,
  output logic                 HREADYOUT,
  output nandPkg::word_t       HRDATA,
  input  logic                 rb,
  input  logic                 busy,
  input  logic                 done,
  input  nandPkg::word_t       rdWord,
  output nandPkg::seqReq_t     seqReq,
  output nandPkg::nandTiming_t tim,
  output logic                 irq
);
  import nandPkg::*;

  logic    accept;
  logic    needSeq;
  regOfs_t addrOfs;
  logic    dpValid;   // first cycle of a data phase
  logic    dpWrite;
  regOfs_t dpOfs;
  logic    rbMeta;
  logic    rbSync;
  logic    rbPrev;

  //==========================================================================
  // address phase
  //==========================================================================
  assign accept  = HSEL && HREADY && HTRANS[1];
  assign addrOfs = HADDR[5:0];

  always_comb begin
    case (addrOfs)
      `NAND_CMD_OFS, `NAND_ADR_OFS, `NAND_STATUS_OFS: needSeq = HWRITE;
      `NAND_DATA_OFS: needSeq = 1'b1;
      default:        needSeq = 1'b0;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      dpValid <= 1'b0;
      dpWrite <= 1'b0;
      dpOfs   <= '0;
    end else begin
      dpValid <= accept;
      if (accept) begin
        dpWrite <= HWRITE;
        dpOfs   <= addrOfs;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      HREADYOUT <= 1'b1;
    end else if (done) begin
      HREADYOUT <= 1'b1;
    end else if (accept && needSeq) begin
      HREADYOUT <= 1'b0;   // low through the request cycle
    end
  end

  //==========================================================================
  // data phase
  //==========================================================================
  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      tim <= '0;
    end else if (dpValid && dpWrite && dpOfs == `NAND_CFG_OFS) begin
      tim <= nandTiming_t'(HWDATA[$bits(nandTiming_t)-1:0]);
    end
  end

  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      HRDATA <= '0;
    end else if (done && !dpWrite) begin
      HRDATA <= rdWord;   // end of a data read
    end else if (accept && !HWRITE) begin
      case (addrOfs)
        `NAND_STATUS_OFS: HRDATA <= {31'd0, rbSync};
        `NAND_CFG_OFS:    HRDATA <= word_t'(tim);
        default:          HRDATA <= '0;
      endcase
    end
  end

  always_comb begin
    seqReq.valid   = 1'b0;
    seqReq.kind    = seqCmd;
    seqReq.payload = HWDATA;
    if (dpValid) begin
      case (dpOfs)
        `NAND_CMD_OFS: begin
          seqReq.valid = dpWrite;
          seqReq.kind  = seqCmd;
        end
        `NAND_ADR_OFS: begin
          seqReq.valid = dpWrite;
          seqReq.kind  = seqAddr;
        end
        `NAND_STATUS_OFS: begin
          seqReq.valid   = dpWrite;   // flash reset
          seqReq.kind    = seqCmd;
          seqReq.payload = word_t'(`NAND_RESET_CMD);
        end
        `NAND_DATA_OFS: begin
          seqReq.valid = 1'b1;
          seqReq.kind  = dpWrite ? seqWrite : seqRead;
        end
        default: ;
      endcase
    end
  end

  //==========================================================================
  // ready/busy sync and interrupt
  //==========================================================================
  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      rbMeta <= 1'b1;
      rbSync <= 1'b1;
      rbPrev <= 1'b1;
      irq    <= 1'b0;
    end else begin
      rbMeta <= rb;
      rbSync <= rbMeta;
      rbPrev <= rbSync;
      irq    <= rbSync && !rbPrev && !busy;   // rise while idle only
    end
  end

endmodule

/* design/nandSequencer.sv */
//==========================================================================
// NAND bus cycle sequencer.
// Each byte runs setup, strobe and hold phases of tim.x+1 cycles each.
// A request is taken only while idle; tim must stay stable during a
// sequence. Read bytes are sampled on the last strobe cycle.
//==========================================================================
`timescale 1ns/10ps
`include "nand_config.svh"

module nandSequencer (
  input  logic                 HCLK,
  input  logic                 HRST_N,
  input  nandPkg::seqReq_t     seqReq,
  input  nandPkg::nandTiming_t tim,
  input  nandPkg::byte_t       dataIn,
  output nandPkg::nandPins_t   pins,
  output logic                 busy,
  output logic                 done,
  output nandPkg::word_t       rdWord
);
  import nandPkg::*;

  localparam int ByteCntW = $clog2(`NAND_WORD_BYTES + 1);

  seqState_t           state;
  seqKind_t            kind;
  timeCnt_t            tCnt;
  logic [ByteCntW-1:0] byteCnt;    // bytes left, current one included
  word_t               dataShift;  // out lowest byte first, or read word
  logic                phaseEnd;
  logic                lastByte;
  logic                isRead;

  assign phaseEnd = (tCnt == '0);
  assign lastByte = (byteCnt == ByteCntW'(1));
  assign isRead   = (kind == seqRead);

  //==========================================================================
  // phase state machine
  //==========================================================================
  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      state   <= idle;
      kind    <= seqCmd;
      tCnt    <= '0;
      byteCnt <= '0;
    end else begin
      case (state)
        idle: begin
          if (seqReq.valid) begin
            state   <= setup;
            kind    <= seqReq.kind;
            tCnt    <= tim.setup;
            if (seqReq.kind == seqCmd) begin
              byteCnt <= ByteCntW'(1);
            end else begin
              byteCnt <= ByteCntW'(`NAND_WORD_BYTES);
            end
          end
        end
        setup: begin
          if (phaseEnd) begin
            state <= strobe;
            tCnt  <= tim.strobe;
          end else begin
            tCnt <= tCnt - 1'b1;
          end
        end
        strobe: begin
          if (phaseEnd) begin
            state <= hold;
            tCnt  <= tim.hold;
          end else begin
            tCnt <= tCnt - 1'b1;
          end
        end
        hold: begin
          if (phaseEnd) begin
            if (lastByte) begin
              state <= idle;
            end else begin
              state   <= setup;   // next byte
              tCnt    <= tim.setup;
              byteCnt <= byteCnt - 1'b1;
            end
          end else begin
            tCnt <= tCnt - 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  //==========================================================================
  // byte shifter
  //==========================================================================
  always_ff @(posedge HCLK) begin
    if (state == idle && seqReq.valid) begin
      dataShift <= seqReq.payload;
    end else if (state == strobe && phaseEnd && isRead) begin
      dataShift <= {dataIn, dataShift[31:8]};   // first byte ends in 7:0
    end else if (state == hold && phaseEnd && !lastByte && !isRead) begin
      dataShift <= {8'h00, dataShift[31:8]};
    end
  end

  //==========================================================================
  // pins and status
  //==========================================================================
  always_comb begin
    pins.ceN     = (state == idle);
    pins.cle     = (state != idle) && (kind == seqCmd);
    pins.ale     = (state != idle) && (kind == seqAddr);
    pins.weN     = !((state == strobe) && !isRead);
    pins.reN     = !((state == strobe) && isRead);
    pins.dataEn  = ((state == strobe) || (state == hold)) && !isRead;
    pins.dataOut = dataShift[7:0];
  end

  assign busy   = (state != idle) || seqReq.valid;   // covers request cycle
  assign done   = (state == hold) && phaseEnd && lastByte;
  assign rdWord = dataShift;

endmodule

/* design/nandCtrlTop.sv */
//==========================================================================
// NAND flash controller top, AHB-Lite slave side to flash pins.
// One transfer is in flight at a time; the slave stalls with HREADYOUT.
// dataOut is valid on the flash bus only while pins.dataEn is set.
//==========================================================================
`timescale 1ns/10ps

module nandCtrlTop (
  input  logic               HCLK,
  input  logic               HRST_N,
  input  logic               HSEL,
  input  logic               HWRITE,
  input  logic               HREADY,
  input  nandPkg::word_t     HADDR,
  input  nandPkg::word_t     HWDATA,
  input  logic [1:0]         HTRANS,
  output logic               HREADYOUT,
  output nandPkg::word_t     HRDATA,
  input  logic               rb,
  input  nandPkg::byte_t     dataIn,
  output nandPkg::nandPins_t pins,
  output logic               irq
);
  import nandPkg::*;

  seqReq_t     seqReq;
  nandTiming_t tim;
  logic        busy;
  logic        done;
  word_t       rdWord;

  ahbRegs ahbRegs_i (
    .HCLK      (HCLK),
    .HRST_N    (HRST_N),
    .HSEL      (HSEL),
    .HWRITE    (HWRITE),
    .HREADY    (HREADY),
    .HTRANS    (HTRANS),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HREADYOUT (HREADYOUT),
    .HRDATA    (HRDATA),
    .rb        (rb),
    .busy      (busy),
    .done      (done),
    .rdWord    (rdWord),
    .seqReq    (seqReq),
    .tim       (tim),
    .irq       (irq)
  );

  nandSequencer nandSequencer_i (
    .HCLK   (HCLK),
    .HRST_N (HRST_N),
    .seqReq (seqReq),
    .tim    (tim),
    .dataIn (dataIn),
    .pins   (pins),
    .busy   (busy),
    .done   (done),
    .rdWord (rdWord)
  );

endmodule

/* test/nandCtrl_sva.sv */
//==========================================================================
// Protocol checker bound into the NAND controller top.
// Strobe width is checked against the current timing register, which
// must not change while a sequence runs.
//==========================================================================
`timescale 1ns/10ps

module nandCtrlSva (
  input logic                 HCLK,
  input logic                 HRST_N,
  input logic                 HREADYOUT,
  input logic                 busy,
  input nandPkg::nandPins_t   pins,
  input nandPkg::nandTiming_t tim
);

  logic [3:0] weLowCnt;   // cycles of the current weN low pulse

  always_ff @(posedge HCLK or negedge HRST_N) begin
    if (!HRST_N) begin
      weLowCnt <= '0;
    end else if (!pins.weN) begin
      weLowCnt <= weLowCnt + 4'd1;
    end else begin
      weLowCnt <= '0;
    end
  end

  strobeExcl: assert property (@(posedge HCLK) disable iff (!HRST_N)
    !(!pins.weN && !pins.reN)) else $error("weN and reN low together");

  latchExcl: assert property (@(posedge HCLK) disable iff (!HRST_N)
    !(pins.cle && pins.ale)) else $error("cle and ale high together");

  weWidth: assert property (@(posedge HCLK) disable iff (!HRST_N)
    $rose(pins.weN) |-> weLowCnt == 4'(tim.strobe) + 4'd1)
    else $error("weN low pulse width differs from strobe timing");

  readyIdle: assert property (@(posedge HCLK) disable iff (!HRST_N)
    !busy |-> HREADYOUT) else $error("HREADYOUT low while sequencer idle");

endmodule

bind nandCtrlTop nandCtrlSva nandCtrlSva_i (
  .HCLK      (HCLK),
  .HRST_N    (HRST_N),
  .HREADYOUT (HREADYOUT),
  .busy      (busy),
  .pins      (pins),
  .tim       (tim)
);

/* test/nandCtrlTb.sv */
//==========================================================================
// Testbench of the NAND flash controller.
// AHB-Lite master with HREADY looped back from HREADYOUT, single transfers
// only. The flash model records each weN rise and answers reads from a
// byte list filled by $urandom with seed 16.
//==========================================================================
`timescale 1ns/10ps
`include "nand_config.svh"

module nandCtrlTb;
  import nandPkg::*;

  localparam int NumXfers    = 20;        // transfers issued below, rounded up
  localparam int WorstCycles = 4 * 24;    // four bytes at the slowest timing
  localparam int MaxWait     = WorstCycles + 16;

  logic        HCLK = 1'b0;
  logic        HRST_N;
  logic        HSEL;
  logic        HWRITE;
  logic        HREADY;
  logic [1:0]  HTRANS;
  word_t       HADDR;
  word_t       HWDATA;
  logic        HREADYOUT;
  word_t       HRDATA;
  logic        rb;
  byte_t       dataIn;
  nandPins_t   pins;
  logic        irq;

  string       testName = "reset";
  logic [9:0]  expQ[$];                   // {cle, ale, byte}
  logic [9:0]  gotCycle;
  logic [9:0]  expCycle;
  byte_t       rdList[64];
  int          rdIdx = 0;
  int          rdBase = 0;
  logic        inStrobe = 1'b0;
  int          irqCount = 0;
  logic        failReported = 1'b0;
  logic        passDone = 1'b0;
  word_t       rdata;
  word_t       expWord;

  wire weN = pins.weN;

  assign HREADY = HREADYOUT;              // single slave on the bus

  nandCtrlTop nandCtrlTop_i (
    .HCLK      (HCLK),
    .HRST_N    (HRST_N),
    .HSEL      (HSEL),
    .HWRITE    (HWRITE),
    .HREADY    (HREADY),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HTRANS    (HTRANS),
    .HREADYOUT (HREADYOUT),
    .HRDATA    (HRDATA),
    .rb        (rb),
    .dataIn    (dataIn),
    .pins      (pins),
    .irq       (irq)
  );

  initial begin
    forever #2 HCLK = ~HCLK;
  end

  task automatic failRun(input string msg);
    failReported = 1'b1;
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  //==========================================================================
  // reference model
  //==========================================================================
  function automatic int byteCount(input regOfs_t ofs);
    if (ofs == `NAND_CMD_OFS || ofs == `NAND_STATUS_OFS) begin
      return 1;
    end
    return `NAND_WORD_BYTES;
  endfunction

  function automatic logic [9:0] expectedCycle(input regOfs_t ofs, input word_t wdata,
                                               input int idx);
    case (ofs)
      `NAND_CMD_OFS:    return {2'b10, wdata[7:0]};
      `NAND_STATUS_OFS: return {2'b10, `NAND_RESET_CMD};
      `NAND_ADR_OFS:    return {2'b01, wdata[8*idx +: 8]};
      default:          return {2'b00, wdata[8*idx +: 8]};
    endcase
  endfunction

  function automatic word_t expectedWord(input int base);
    word_t w;
    for (int i = 0; i < `NAND_WORD_BYTES; i++) begin
      w[8*i +: 8] = rdList[(base + i) % 64];
    end
    return w;
  endfunction

  //==========================================================================
  // flash model
  //==========================================================================
  always @(posedge weN) begin
    if (HRST_N === 1'b1) begin
      gotCycle = {pins.cle, pins.ale, pins.dataOut};
      assert (!pins.ceN && pins.dataEn)
        else failRun($sformatf("write strobe without ceN or dataEn in test %s", testName));
      assert (expQ.size() > 0)
        else failRun($sformatf("unexpected flash write cycle %h in test %s", gotCycle,
                               testName));
      expCycle = expQ.pop_front();
      assert (gotCycle == expCycle)
        else failRun($sformatf("error %s: expected %h, actual %h", testName, expCycle,
                               gotCycle));
    end
  end

  always @(negedge HCLK) begin
    if (!pins.reN) begin
      assert (!pins.ceN && !pins.dataEn)
        else failRun($sformatf("read strobe with bad ceN or dataEn in test %s", testName));
      if (!inStrobe) begin
        dataIn   = rdList[rdIdx % 64];   // next byte for this strobe
        rdIdx    = rdIdx + 1;
        inStrobe = 1'b1;
      end
    end else begin
      inStrobe = 1'b0;
    end
  end

  always @(negedge HCLK) begin
    if (irq) irqCount = irqCount + 1;
  end

  //==========================================================================
  // AHB tasks
  //==========================================================================
  task automatic ahbAccess(input regOfs_t ofs, input logic write, input word_t wdata,
                           output word_t result);
    int waitCycles;
    @(negedge HCLK);
    HSEL   = 1'b1;
    HTRANS = 2'b10;                      // NONSEQ
    HWRITE = write;
    HADDR  = word_t'(ofs);
    @(negedge HCLK);
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    HWDATA = wdata;
    waitCycles = 0;
    while (!HREADYOUT) begin
      assert (waitCycles < MaxWait)
        else failRun($sformatf("HREADYOUT stayed low too long in test %s", testName));
      waitCycles++;
      @(negedge HCLK);
    end
    result = HRDATA;
  endtask

  task automatic verifyIdlePins();
    assert (HREADYOUT && pins.ceN && pins.weN && pins.reN)
      else failRun($sformatf("HREADYOUT or a flash strobe not idle in test %s", testName));
    assert (!pins.cle && !pins.ale && !pins.dataEn && !irq)
      else failRun($sformatf("cle, ale, dataEn or irq set while idle in test %s", testName));
  endtask

  task automatic writeReg(input regOfs_t ofs, input word_t wdata);
    word_t unused;
    if (ofs != `NAND_CFG_OFS) begin
      for (int i = 0; i < byteCount(ofs); i++) begin
        expQ.push_back(expectedCycle(ofs, wdata, i));
      end
    end
    ahbAccess(ofs, 1'b1, wdata, unused);
    assert (expQ.size() == 0)
      else failRun($sformatf("flash write cycles missing in test %s", testName));
    verifyIdlePins();
  endtask

  task automatic readData();
    expWord = expectedWord(rdBase);
    rdBase  = rdBase + `NAND_WORD_BYTES;
    ahbAccess(`NAND_DATA_OFS, 1'b0, '0, rdata);
    assert (rdata == expWord)
      else failRun($sformatf("error %s: expected %h, actual %h", testName, expWord, rdata));
    verifyIdlePins();
  endtask

  task automatic checkStatus();
    ahbAccess(`NAND_STATUS_OFS, 1'b0, '0, rdata);
    assert (rdata == {31'd0, rb})
      else failRun($sformatf("error %s: expected %h, actual %h", testName, {31'd0, rb}, rdata));
  endtask

  //==========================================================================
  // test sequence
  //==========================================================================
  initial begin
    void'($urandom(16));
    for (int i = 0; i < 64; i++) begin
      rdList[i] = byte_t'($urandom);
    end
    HRST_N = 1'b0;
    HSEL   = 1'b0;
    HWRITE = 1'b0;
    HTRANS = 2'b00;
    HADDR  = '0;
    HWDATA = '0;
    rb     = 1'b1;
    dataIn = '0;
    repeat (2) @(negedge HCLK);
    HRST_N = 1'b1;
    verifyIdlePins();

    testName = "command write";
    writeReg(`NAND_CFG_OFS, $urandom);
    writeReg(`NAND_CMD_OFS, $urandom);
    testName = "address write";
    writeReg(`NAND_ADR_OFS, $urandom);
    testName = "data write";
    writeReg(`NAND_DATA_OFS, $urandom);

    for (int i = 0; i < 4; i++) begin
      testName = $sformatf("data read %0d", i);
      writeReg(`NAND_CFG_OFS, $urandom);
      readData();
    end

    testName = "status read";
    checkStatus();
    testName = "status write";
    writeReg(`NAND_STATUS_OFS, $urandom);

    testName = "irq idle";
    irqCount = 0;
    rb = 1'b0;
    repeat (4) @(negedge HCLK);
    checkStatus();
    rb = 1'b1;
    repeat (6) @(negedge HCLK);
    assert (irqCount == 1)
      else failRun($sformatf("error %s: expected %0d, actual %0d", testName, 1, irqCount));

    testName = "irq busy";
    writeReg(`NAND_CFG_OFS, 32'h1FF);   // slowest timing
    irqCount = 0;
    fork
      writeReg(`NAND_DATA_OFS, $urandom);
      begin
        repeat (8) @(negedge HCLK);
        rb = 1'b0;
        repeat (4) @(negedge HCLK);
        rb = 1'b1;
      end
    join
    repeat (6) @(negedge HCLK);
    assert (irqCount == 0)
      else failRun($sformatf("error %s: expected %0d, actual %0d", testName, 0, irqCount));

    passDone = 1'b1;
    $display("Test OK");
    $finish;
  end

  // watchdog
  initial begin
    #((NumXfers * WorstCycles + 200) * 4);
    failRun("simulation timed out");
  end

  final begin
    if (!passDone && !failReported) $display("Test FAILED");   // stopped by an assertion
  end

endmodule

/* list.f */
+incdir+design
design/nandPkg.sv
design/ahbRegs.sv
design/nandSequencer.sv
design/nandCtrlTop.sv
test/nandCtrl_sva.sv
test/nandCtrlTb.sv

/* run.sh */
#!/bin/sh
# build and run the NAND controller testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f list.f --top-module nandCtrlTb -o simv \
  > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
